// ==== frame_fifo_pkg.sv ====
// fixed 16-word by 8-bit frame FIFO types; the only user bit is the bad-frame marker on last beats
`default_nettype none

package frame_fifo_pkg;

    // data byte width
    localparam int DATA_W = 8;

    // words of storage which must stay a power of two
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_W = 4;

    // pointer with one extra wrap bit so full and empty differ
    typedef logic [ADDR_W:0] ptr_t;

    // pointer distance that means the storage is completely used
    localparam ptr_t PTR_WRAP = ptr_t'(FIFO_DEPTH);

    // one stream beat as stored in the RAM
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              user;
    } axis_beat_t;

    // status word whose pulses are one cycle wide
    typedef struct packed {
        ptr_t depth;
        ptr_t depth_commit;
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

endpackage

`default_nettype wire

// ==== frame_fifo_write.sv ====
// write side of the frame FIFO; frames over 16 beats are drained and dropped, user on last marks bad
`timescale 1ns/100ps
`default_nettype none

module frame_fifo_write import frame_fifo_pkg::*; (
    input  wire logic        m_clk,
    input  wire logic        m_rst,

    input  wire axis_beat_t  s_beat,
    input  wire logic        s_valid,
    output logic             s_ready,

    input  wire ptr_t        rd_ptr,

    output logic             wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output axis_beat_t       wr_beat,

    output ptr_t             commit_ptr,
    output fifo_status_t     status
);

    ptr_t wr_ptr;
    ptr_t wr_ptr_next;
    logic dropping;
    logic full;
    logic oversize;
    logic accept;
    logic drop_beat;

    // full against the read side, oversize against the start of the current frame
    assign full = (ptr_t'(wr_ptr - rd_ptr) == PTR_WRAP);
    assign oversize = (ptr_t'(wr_ptr - commit_ptr) == PTR_WRAP);

    // an oversize frame keeps flowing in so it can drain away
    assign s_ready = !full || oversize;
    assign accept = s_valid && s_ready;
    assign drop_beat = dropping || oversize;

    assign wr_ptr_next = ptr_t'(wr_ptr + 1'b1);

    assign wr_en = accept && !drop_beat;
    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign wr_beat = s_beat;

    always_ff @(posedge m_clk) begin
        if (m_rst) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            dropping <= 1'b0;
            status <= '0;
        end else begin
            // pulses default low
            status.overflow <= 1'b0;
            status.bad_frame <= 1'b0;
            status.good_frame <= 1'b0;

            if (accept) begin
                if (drop_beat) begin
                    dropping <= 1'b1;
                    if (s_beat.last) begin
                        // a dropped frame ends here and rewinds to the last commit
                        wr_ptr <= commit_ptr;
                        dropping <= 1'b0;
                        status.overflow <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr_next;
                    if (s_beat.last) begin
                        if (s_beat.user) begin
                            // a bad frame discards everything since the commit
                            wr_ptr <= commit_ptr;
                            status.bad_frame <= 1'b1;
                        end else begin
                            // frame complete and visible to the read side
                            commit_ptr <= wr_ptr_next;
                            status.good_frame <= 1'b1;
                        end
                    end
                end
            end

            // depths trail the pointers by one cycle
            status.depth <= ptr_t'(wr_ptr - rd_ptr);
            status.depth_commit <= ptr_t'(commit_ptr - rd_ptr);
        end
    end

endmodule

`default_nettype wire

// ==== frame_fifo_ram.sv ====
// dual-port storage; the read word appears one cycle after rd_en and holds while rd_en is low
`timescale 1ns/100ps
`default_nettype none

module frame_fifo_ram import frame_fifo_pkg::*; (
    input  wire logic              m_clk,

    input  wire logic              wr_en,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire axis_beat_t        wr_beat,

    input  wire logic              rd_en,
    input  wire logic [ADDR_W-1:0] rd_addr,
    output axis_beat_t             rd_beat
);

    axis_beat_t mem [FIFO_DEPTH];

    always_ff @(posedge m_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // registered read that forms pipeline stage 0
    always_ff @(posedge m_clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== frame_fifo_read.sv ====
// read side; only committed frames are read, so m_valid stays high across a frame while m_ready allows
`timescale 1ns/100ps
`default_nettype none

module frame_fifo_read import frame_fifo_pkg::*; (
    input  wire logic         m_clk,
    input  wire logic         m_rst,

    input  wire ptr_t         commit_ptr,
    output ptr_t              rd_ptr,

    output logic              rd_en,
    output logic [ADDR_W-1:0] rd_addr,
    input  wire axis_beat_t   rd_beat,

    output axis_beat_t        m_beat,
    output logic              m_valid,
    input  wire logic         m_ready
);

    // stage 0 is the RAM read register, stage 1 is the output register
    logic s0_valid;
    logic empty;
    logic out_ready;
    logic s0_free;

    assign empty = (rd_ptr == commit_ptr);

    // output register can take a word when it is empty or being taken
    assign out_ready = !m_valid || m_ready;

    // stage 0 is free next cycle if it is empty or moves down now
    assign s0_free = !s0_valid || out_ready;

    assign rd_en = !empty && s0_free;
    assign rd_addr = rd_ptr[ADDR_W-1:0];

    always_ff @(posedge m_clk) begin
        if (m_rst) begin
            rd_ptr <= '0;
            s0_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= ptr_t'(rd_ptr + 1'b1);
            end

            if (s0_free) begin
                s0_valid <= rd_en;
            end

            if (out_ready) begin
                m_valid <= s0_valid;
            end
        end
    end

    // output payload follows stage 0 whenever a word moves down
    always_ff @(posedge m_clk) begin
        if (out_ready && s0_valid) begin
            m_beat <= rd_beat;
        end
    end

endmodule

`default_nettype wire

// ==== frame_fifo.sv ====
// single-clock store-and-forward frame FIFO of 16 beats; longer frames and bad frames are dropped
`timescale 1ns/100ps
`default_nettype none

module frame_fifo import frame_fifo_pkg::*; (
    input  wire logic       m_clk,
    input  wire logic       m_rst,

    input  wire axis_beat_t s_beat,
    input  wire logic       s_valid,
    output logic            s_ready,

    output axis_beat_t      m_beat,
    output logic            m_valid,
    input  wire logic       m_ready,

    output fifo_status_t    status
);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    axis_beat_t        wr_beat;

    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    axis_beat_t        rd_beat;

    ptr_t              commit_ptr;
    ptr_t              rd_ptr;

    frame_fifo_write write_i (
        .m_clk      (m_clk),
        .m_rst      (m_rst),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .rd_ptr     (rd_ptr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_beat    (wr_beat),
        .commit_ptr (commit_ptr),
        .status     (status)
    );

    frame_fifo_ram ram_i (
        .m_clk   (m_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    frame_fifo_read read_i (
        .m_clk      (m_clk),
        .m_rst      (m_rst),
        .commit_ptr (commit_ptr),
        .rd_ptr     (rd_ptr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_beat    (rd_beat),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready)
    );

endmodule

`default_nettype wire

// ==== tb_frame_fifo.sv ====
// random frames from seed 29 until the first mismatch; frames over 16 beats must be dropped
`timescale 1ns/100ps
`default_nettype none

module tb_frame_fifo import frame_fifo_pkg::*; ();

    localparam int NUM_FRAMES = 60;
    localparam int HANDSHAKE_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT = 4000;

    typedef enum int {FATE_GOOD, FATE_BAD, FATE_OVERFLOW} fate_t;

    logic         m_clk = 1'b0;
    logic         m_rst;
    axis_beat_t   s_beat;
    logic         s_valid;
    logic         s_ready;
    axis_beat_t   m_beat;
    logic         m_valid;
    logic         m_ready;
    fifo_status_t status;

    logic [31:0] stim_state = 32'd29;
    // stall stream starts from the inverted seed so it does not track the stimulus
    logic [31:0] stall_state = ~32'd29;

    axis_beat_t expected_q[$];
    axis_beat_t exp_beat;

    int good_sent = 0;
    int bad_sent = 0;
    int overflow_sent = 0;
    int good_seen = 0;
    int bad_seen = 0;
    int overflow_seen = 0;

    frame_fifo dut_i (
        .m_clk   (m_clk),
        .m_rst   (m_rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .status  (status)
    );

    always #4 m_clk = ~m_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // oversize wins over bad and anything else is delivered
    function automatic fate_t frame_fate(input int len, input logic bad);
        if (len > FIFO_DEPTH) begin
            return FATE_OVERFLOW;
        end else if (bad) begin
            return FATE_BAD;
        end else begin
            return FATE_GOOD;
        end
    endfunction

    task automatic fail_with(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_with($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
        end
    endtask

    // offer one beat and hold it until s_ready is seen high before a rising edge
    task automatic send_beat(input axis_beat_t beat);
        int waited;
        waited = 0;
        s_beat <= beat;
        s_valid <= 1'b1;
        @(negedge m_clk);
        while (!s_ready) begin
            waited++;
            if (waited > HANDSHAKE_TIMEOUT) begin
                fail_with("s_ready stayed low too long while a beat was offered");
            end
            @(negedge m_clk);
        end
        @(posedge m_clk);
    endtask

    // random m_ready that is low about one cycle in three
    initial begin
        m_ready <= 1'b0;
        forever begin
            @(posedge m_clk);
            stall_state = xorshift(stall_state);
            m_ready <= !m_rst && ((stall_state % 3) != 0);
        end
    end

    // compare every output transfer against the expected queue
    always @(negedge m_clk) begin
        if (!m_rst && m_valid && m_ready) begin
            if (expected_q.size() == 0) begin
                fail_with("output produced a beat that no good frame accounts for");
            end else begin
                exp_beat = expected_q.pop_front();
                check("m_beat.data", 32'(m_beat.data), 32'(exp_beat.data));
                check("m_beat.last", 32'(m_beat.last), 32'(exp_beat.last));
                check("m_beat.user", 32'(m_beat.user), 32'(exp_beat.user));
            end
        end
    end

    // status pulses are one cycle wide, so one sample per cycle counts each once
    always @(negedge m_clk) begin
        if (!m_rst) begin
            good_seen += int'(status.good_frame);
            bad_seen += int'(status.bad_frame);
            overflow_seen += int'(status.overflow);
            check("status.depth_in_range", 32'(32'(status.depth) <= 32'(FIFO_DEPTH)), 32'd1);
        end
    end

    initial begin
        int len;
        logic bad;
        fate_t fate;
        axis_beat_t beat;
        int waited;

        s_beat <= '0;
        s_valid <= 1'b0;
        m_rst <= 1'b1;
        repeat (16) @(posedge m_clk);
        m_rst <= 1'b0;
        @(posedge m_clk);
        @(negedge m_clk);
        check("m_valid", 32'(m_valid), 32'd0);
        check("s_ready", 32'(s_ready), 32'd1);
        check("status", 32'(status), 32'd0);
        @(posedge m_clk);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            stim_state = xorshift(stim_state);
            len = 1 + int'(stim_state % 20);
            stim_state = xorshift(stim_state);
            bad = ((stim_state % 5) == 0);
            fate = frame_fate(len, bad);
            case (fate)
                FATE_GOOD: good_sent++;
                FATE_BAD: bad_sent++;
                default: overflow_sent++;
            endcase
            for (int i = 0; i < len; i++) begin
                stim_state = xorshift(stim_state);
                beat.data = stim_state[DATA_W-1:0];
                beat.last = (i == len - 1);
                beat.user = beat.last && bad;
                if (fate == FATE_GOOD) begin
                    expected_q.push_back(beat);
                end
                send_beat(beat);
                // occasional idle gap on the input
                stim_state = xorshift(stim_state);
                if (stim_state[1:0] == 2'b00) begin
                    s_valid <= 1'b0;
                    repeat (1 + int'(stim_state[3:2])) @(posedge m_clk);
                end
            end
        end
        s_valid <= 1'b0;

        waited = 0;
        while (expected_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                fail_with("good frames were not fully delivered before the drain timeout");
            end
            @(posedge m_clk);
        end
        repeat (2) @(posedge m_clk);
        @(negedge m_clk);

        check("m_valid", 32'(m_valid), 32'd0);
        check("status.depth", 32'(status.depth), 32'd0);
        check("status.depth_commit", 32'(status.depth_commit), 32'd0);
        check("good_frame_count", 32'(good_seen), 32'(good_sent));
        check("bad_frame_count", 32'(bad_seen), 32'(bad_sent));
        check("overflow_count", 32'(overflow_seen), 32'(overflow_sent));

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
frame_fifo_pkg.sv
frame_fifo_write.sv
frame_fifo_ram.sv
frame_fifo_read.sv
frame_fifo.sv
tb_frame_fifo.sv

// ==== Makefile ====
# Verilator build and run for the frame FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_fifo
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= Test completed successfully

SOURCES := $(wildcard *.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
